// File: sources.f
+incdir+design
design/sensor_pkg.sv
design/servo_pkg.sv
design/tick_gen.sv
design/track_ctrl.sv
design/servo_driver.sv
design/pwm_gen.sv
design/solar_tracker_top.sv
testbench/tracker_props.sv
testbench/tb_solar_tracker.sv

// File: Bender.yml
package:
  name: solar_tracker

export_include_dirs:
  - design

sources:
  # rtl in compile order, packages first
  - include_dirs:
      - design
    files:
      - design/sensor_pkg.sv
      - design/servo_pkg.sv
      - design/tick_gen.sv
      - design/track_ctrl.sv
      - design/servo_driver.sv
      - design/pwm_gen.sv
      - design/solar_tracker_top.sv

  # testbench and bound assertions
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tracker_props.sv
      - testbench/tb_solar_tracker.sv

// File: testbench/tb_solar_tracker.sv
`timescale 1ns/1ps
`include "tracker_defines.svh"

module tb_solar_tracker;

   localparam int NUM_ROWS = 10;
   // one frame in clk cycles
   localparam int FRAME_CYC = `TRK_FRAME_US * `TRK_TICK_DIV;

   // one stimulus row with its expected end state
   typedef struct packed {
      logic                    en;
      logic                    rnd;
      logic [`TRK_LIGHT_W-1:0] east;
      logic [`TRK_LIGHT_W-1:0] west;
      logic [`TRK_LIGHT_W-1:0] up;
      logic [`TRK_LIGHT_W-1:0] down;
      logic [7:0]              frames;
      logic [`TRK_POS_W-1:0]   exp_az;
      logic [`TRK_POS_W-1:0]   exp_el;
      logic                    exp_locked;
   } row_t;

   logic                      clk;
   logic                      rst;
   logic                      en;
   sensor_pkg::light_sample_t light;
   logic                      servo_az;
   logic                      servo_el;
   servo_pkg::servo_status_t  status_az;
   servo_pkg::servo_status_t  status_el;
   logic                      locked;

   row_t   rows [NUM_ROWS];
   row_t   row;
   integer seed;
   int     n_checks;
   int     n_errors;
   int     model_az;
   int     model_el;
   int     exp_w_az;
   int     exp_w_el;
   bit     model_locked;
   bit     move_az;
   bit     move_el;
   bit     quiet;

   solar_tracker_top dut0 (
      .clk       (clk),
      .rst       (rst),
      .en        (en),
      .light     (light),
      .servo_az  (servo_az),
      .servo_el  (servo_el),
      .status_az (status_az),
      .status_el (status_el),
      .locked    (locked)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // en, rnd, east, west, up, down, frames, az, el, locked
   task automatic fill_table();
      rows[0] = '{1'b1, 1'b0, 12'd2000, 12'd1000, 12'd1500, 12'd1500, 8'd3,
                  12'd1400, 12'd1250, 1'b0};
      rows[1] = '{1'b1, 1'b0, 12'd800, 12'd1800, 12'd3000, 12'd1000, 8'd2,
                  12'd1300, 12'd1350, 1'b0};
      // both pairs inside the deadband
      // a difference of -64 is still a stop
      rows[2] = '{1'b1, 1'b0, 12'd1030, 12'd1000, 12'd1000, 12'd1064, 8'd2,
                  12'd1300, 12'd1350, 1'b1};
      // just past the deadband
      rows[3] = '{1'b1, 1'b0, 12'd1065, 12'd1000, 12'd1000, 12'd1000, 8'd1,
                  12'd1350, 12'd1350, 1'b0};
      // run into both end stops
      rows[4] = '{1'b1, 1'b0, 12'd4000, 12'd0, 12'd0, 12'd4000, 8'd20,
                  12'd2000, 12'd500, 1'b1};
      // tracking off with the light reversed
      rows[5] = '{1'b0, 1'b0, 12'd0, 12'd4000, 12'd4000, 12'd0, 8'd3,
                  12'd2000, 12'd500, 1'b1};
      rows[6] = '{1'b1, 1'b0, 12'd0, 12'd4000, 12'd4000, 12'd0, 8'd2,
                  12'd1900, 12'd600, 1'b0};
      rows[7] = '{1'b1, 1'b0, 12'd0, 12'd4000, 12'd2000, 12'd2000, 8'd30,
                  12'd500, 12'd600, 1'b1};
      // random light with expectations from the model
      rows[8] = '{1'b1, 1'b1, 12'd0, 12'd0, 12'd0, 12'd0, 8'd3, 12'd0, 12'd0, 1'b0};
      rows[9] = '{1'b1, 1'b1, 12'd0, 12'd0, 12'd0, 12'd0, 8'd3, 12'd0, 12'd0, 1'b0};
   endtask

   // axis would move this frame
   // limit vetoes included
   function automatic bit wants_move(input int pos, input int pos_side, input int neg_side);
      int diff;
      diff = pos_side - neg_side;
      return (diff > `TRK_DEADBAND && pos < `TRK_POS_MAX) ||
             (diff < -`TRK_DEADBAND && pos > `TRK_POS_MIN);
   endfunction

   // one step toward the brighter side
   // clamped at the end stops
   function automatic int stepped_pos(input int pos, input int pos_side, input int neg_side);
      int diff;
      int next;
      diff = pos_side - neg_side;
      next = pos;
      if (diff > `TRK_DEADBAND) begin
         next = pos + `TRK_STEP_US;
         if (next > `TRK_POS_MAX) next = `TRK_POS_MAX;
      end else if (diff < -`TRK_DEADBAND) begin
         next = pos - `TRK_STEP_US;
         if (next < `TRK_POS_MIN) next = `TRK_POS_MIN;
      end
      return next;
   endfunction

   task automatic check_val(input string name, input int got, input int exp);
      n_checks++;
      if (got != exp) begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic stop_on_timeout(input string what);
      n_errors++;
      $display("timeout at %0t: %s", $time, what);
      $display("checks: %0d  errors: %0d", n_checks, n_errors);
      $display("TESTS FAILED");
      $finish;
   endtask

   // returns on the negedge where servo_az first reads high
   task automatic wait_pulse_start();
      int   cnt;
      logic last;
      cnt  = 0;
      last = servo_az;
      @(negedge clk);
      while (!(servo_az && !last) && cnt < 2 * FRAME_CYC) begin
         last = servo_az;
         @(negedge clk);
         cnt++;
      end
      if (!(servo_az && !last)) begin
         stop_on_timeout("no pulse start on servo_az");
      end
   endtask

   // returns on the negedge where servo_az reads low again
   task automatic wait_pulse_end();
      int cnt;
      cnt = 0;
      while (servo_az && cnt < FRAME_CYC) begin
         @(negedge clk);
         cnt++;
      end
      if (servo_az) begin
         stop_on_timeout("servo_az pulse did not end within a frame");
      end
   endtask

   // high time in clk cycles against the width latched at this wrap
   task automatic measure_pulses(input int w_az, input int w_el);
      int cnt;
      int hi_az;
      int hi_el;
      cnt   = 0;
      hi_az = 0;
      hi_el = 0;
      while ((servo_az || servo_el) && cnt < FRAME_CYC) begin
         if (servo_az) hi_az++;
         if (servo_el) hi_el++;
         @(negedge clk);
         cnt++;
      end
      if (servo_az || servo_el) begin
         stop_on_timeout("servo pulse did not end within a frame");
      end
      check_val("servo_az high cycles", hi_az, w_az * `TRK_TICK_DIV);
      check_val("servo_el high cycles", hi_el, w_el * `TRK_TICK_DIV);
   endtask

   initial begin
      seed     = 32'h3c5e;
      n_checks = 0;
      n_errors = 0;
      rst      = 1'b1;
      en       = 1'b0;
      light    = '0;
      fill_table();
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;

      // state right after reset
      @(negedge clk);
      check_val("status_az.position", status_az.position, `TRK_POS_CENTER);
      check_val("status_el.position", status_el.position, `TRK_POS_CENTER);
      check_val("status_az.at_max", status_az.at_max, 0);
      check_val("status_az.at_min", status_az.at_min, 0);
      check_val("status_el.at_max", status_el.at_max, 0);
      check_val("status_el.at_min", status_el.at_min, 0);
      check_val("locked", locked, 0);

      // width is zero until the first wrap
      quiet = 1'b1;
      repeat ((`TRK_FRAME_US - 2) * `TRK_TICK_DIV) begin
         @(negedge clk);
         if (servo_az || servo_el) quiet = 1'b0;
      end
      n_checks++;
      if (!quiet) begin
         n_errors++;
         $display("a servo output went high before the first frame started");
      end

      model_az     = `TRK_POS_CENTER;
      model_el     = `TRK_POS_CENTER;
      model_locked = 1'b0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         row = rows[i];
         if (row.rnd) begin
            row.east = 12'($random(seed));
            row.west = 12'($random(seed));
            row.up   = 12'($random(seed));
            row.down = 12'($random(seed));
         end
         @(posedge clk);
         #1;
         en                      = row.en;
         light.azimuth.pos_side   = row.east;
         light.azimuth.neg_side   = row.west;
         light.elevation.pos_side = row.up;
         light.elevation.neg_side = row.down;

         // first wrap of the row latches the settled previous position
         exp_w_az = model_az;
         exp_w_el = model_el;

         // one decision per frame while en is high
         if (row.rnd) begin
            for (int f = 0; f < row.frames; f++) begin
               if (row.en) begin
                  move_az      = wants_move(model_az, row.east, row.west);
                  move_el      = wants_move(model_el, row.up, row.down);
                  model_locked = !move_az && !move_el;
                  model_az     = stepped_pos(model_az, row.east, row.west);
                  model_el     = stepped_pos(model_el, row.up, row.down);
               end
            end
         end else begin
            model_az     = row.exp_az;
            model_el     = row.exp_el;
            model_locked = row.exp_locked;
         end

         for (int f = 0; f < row.frames; f++) begin
            wait_pulse_start();
            if (f == 0) measure_pulses(exp_w_az, exp_w_el);
         end
         // last step lands a few cycles into this pulse
         wait_pulse_end();

         check_val("status_az.position", status_az.position, model_az);
         check_val("status_el.position", status_el.position, model_el);
         check_val("status_az.at_max", status_az.at_max, model_az >= `TRK_POS_MAX);
         check_val("status_az.at_min", status_az.at_min, model_az <= `TRK_POS_MIN);
         check_val("status_el.at_max", status_el.at_max, model_el >= `TRK_POS_MAX);
         check_val("status_el.at_min", status_el.at_min, model_el <= `TRK_POS_MIN);
         check_val("locked", locked, model_locked);
      end

      $display("checks: %0d  errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: testbench/tracker_props.sv
`timescale 1ns/1ps
`include "tracker_defines.svh"

module tracker_props (
   input logic                     clk,
   input logic                     rst,
   input logic                     step_az,
   input logic                     step_el,
   input servo_pkg::servo_status_t status_az,
   input servo_pkg::servo_status_t status_el,
   input logic                     servo_az,
   input logic                     servo_el
);

   // step strobes last a single cycle
   step_az_single: assert property (@(posedge clk) disable iff (rst) step_az |=> !step_az)
      else $error("step_az high on two cycles in a row");
   step_el_single: assert property (@(posedge clk) disable iff (rst) step_el |=> !step_el)
      else $error("step_el high on two cycles in a row");

   // saturation keeps both widths inside the servo range
   pos_az_range: assert property (@(posedge clk) disable iff (rst)
      status_az.position >= `TRK_POS_MIN && status_az.position <= `TRK_POS_MAX)
      else $error("azimuth position out of range: %0d", status_az.position);
   pos_el_range: assert property (@(posedge clk) disable iff (rst)
      status_el.position >= `TRK_POS_MIN && status_el.position <= `TRK_POS_MAX)
      else $error("elevation position out of range: %0d", status_el.position);

   // sync reset clears both pulse pins
   servo_reset_low: assert property (@(posedge clk) rst |=> (!servo_az && !servo_el))
      else $error("servo output high during reset");

endmodule

bind solar_tracker_top tracker_props props0 (
   .clk       (clk),
   .rst       (rst),
   .step_az   (cmd_az.step),
   .step_el   (cmd_el.step),
   .status_az (status_az),
   .status_el (status_el),
   .servo_az  (servo_az),
   .servo_el  (servo_el)
);

// File: design/solar_tracker_top.sv
`timescale 1ns/1ps

module solar_tracker_top (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      en,
   input  sensor_pkg::light_sample_t light,
   output logic                      servo_az,
   output logic                      servo_el,
   output servo_pkg::servo_status_t  status_az,
   output servo_pkg::servo_status_t  status_el,
   output logic                      locked
);

   // shared microsecond tick keeps both frames aligned
   logic tick;

   // decision pace from the azimuth frame
   logic frame_start;

   servo_pkg::servo_cmd_t cmd_az;
   servo_pkg::servo_cmd_t cmd_el;

   tick_gen u_tick (
      .clk  (clk),
      .rst  (rst),
      .tick (tick)
   );

   track_ctrl u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .en          (en),
      .frame_start (frame_start),
      .light       (light),
      .status_az   (status_az),
      .status_el   (status_el),
      .cmd_az      (cmd_az),
      .cmd_el      (cmd_el),
      .locked      (locked)
   );

   servo_driver drv_az (
      .clk    (clk),
      .rst    (rst),
      .cmd    (cmd_az),
      .status (status_az)
   );

   servo_driver drv_el (
      .clk    (clk),
      .rst    (rst),
      .cmd    (cmd_el),
      .status (status_el)
   );

   pwm_gen pwm_az (
      .clk         (clk),
      .rst         (rst),
      .tick        (tick),
      .position    (status_az.position),
      .frame_start (frame_start),
      .servo       (servo_az)
   );

   // elevation frame start matches azimuth and goes nowhere
   pwm_gen pwm_el (
      .clk         (clk),
      .rst         (rst),
      .tick        (tick),
      .position    (status_el.position),
      .frame_start (),
      .servo       (servo_el)
   );

endmodule

// File: design/pwm_gen.sv
`timescale 1ns/1ps
`include "tracker_defines.svh"

module pwm_gen (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  tick,
   input  logic [`TRK_POS_W-1:0] position,
   output logic                  frame_start,
   output logic                  servo
);

   localparam int FRAME_W = $clog2(`TRK_FRAME_US);
   localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(`TRK_FRAME_US - 1);

   logic [FRAME_W-1:0]    frame_cnt;
   logic [`TRK_POS_W-1:0] width_q;
   logic                  wrap;
   logic [FRAME_W-1:0]    cnt_next;
   logic [`TRK_POS_W-1:0] width_next;

   // last tick of the frame
   assign wrap = tick && (frame_cnt == FRAME_LAST);

   // counter and width as they will be after this tick
   assign cnt_next   = wrap ? '0 : frame_cnt + 1'b1;
   assign width_next = wrap ? position : width_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         frame_cnt   <= '0;
         width_q     <= '0;
         frame_start <= 1'b0;
         servo       <= 1'b0;
      end else begin
         // high while the counter reads 0 after the wrap
         frame_start <= wrap;
         if (tick) begin
            frame_cnt <= cnt_next;
            // width only changes at frame start
            width_q   <= width_next;
            // high for exactly width ticks from the wrap
            servo     <= (cnt_next < width_next);
         end
      end
   end

endmodule

// File: design/servo_driver.sv
`timescale 1ns/1ps
`include "tracker_defines.svh"

module servo_driver (
   input  logic                     clk,
   input  logic                     rst,
   input  servo_pkg::servo_cmd_t    cmd,
   output servo_pkg::servo_status_t status
);

   localparam int POS_W = `TRK_POS_W;

   // limits and step in position units
   localparam logic [POS_W-1:0] POS_MIN    = POS_W'(`TRK_POS_MIN);
   localparam logic [POS_W-1:0] POS_MAX    = POS_W'(`TRK_POS_MAX);
   localparam logic [POS_W-1:0] POS_CENTER = POS_W'(`TRK_POS_CENTER);
   localparam logic [POS_W-1:0] STEP_US    = POS_W'(`TRK_STEP_US);

   logic [POS_W-1:0] pos_q;
   logic [POS_W-1:0] pos_up;
   logic [POS_W-1:0] pos_dn;

   // next position one step up
   // clamp when less than a step of headroom
   assign pos_up = (pos_q >= POS_MAX - STEP_US) ? POS_MAX : pos_q + STEP_US;

   // next position one step down
   // same clamp at the low end
   assign pos_dn = (pos_q <= POS_MIN + STEP_US) ? POS_MIN : pos_q - STEP_US;

   // position moves the cycle after step
   always_ff @(posedge clk) begin
      if (rst) begin
         pos_q <= POS_CENTER;
      end else if (cmd.step) begin
         case (cmd.dir)
            servo_pkg::DIR_CW: begin
               pos_q <= pos_up;
            end
            servo_pkg::DIR_CCW: begin
               pos_q <= pos_dn;
            end
            default: begin
               // stop code keeps the current width
               pos_q <= pos_q;
            end
         endcase
      end
   end

   // limit flags straight from the register
   always_comb begin
      status.position = pos_q;
      status.at_max   = (pos_q >= POS_MAX);
      status.at_min   = (pos_q <= POS_MIN);
   end

endmodule

// File: design/track_ctrl.sv
`timescale 1ns/1ps
`include "tracker_defines.svh"

module track_ctrl (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      en,
   input  logic                      frame_start,
   input  sensor_pkg::light_sample_t light,
   input  servo_pkg::servo_status_t  status_az,
   input  servo_pkg::servo_status_t  status_el,
   output servo_pkg::servo_cmd_t     cmd_az,
   output servo_pkg::servo_cmd_t     cmd_el,
   output logic                      locked
);

   // one extra bit for the signed difference
   localparam int DIFF_W = `TRK_LIGHT_W + 1;
   localparam logic signed [DIFF_W-1:0] DEADBAND = DIFF_W'(`TRK_DEADBAND);

   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      DECIDE = 2'b01,
      STEP   = 2'b10
   } state_e;

   state_e                 state;
   servo_pkg::servo_dir_e  dir_az_d;
   servo_pkg::servo_dir_e  dir_el_d;
   servo_pkg::servo_dir_e  dir_az_q;
   servo_pkg::servo_dir_e  dir_el_q;

   // pair compare with deadband
   // limit flags veto a move toward the end stop
   function automatic servo_pkg::servo_dir_e pick_dir(
      input sensor_pkg::light_pair_t  pair,
      input servo_pkg::servo_status_t status
   );
      logic signed [DIFF_W-1:0] diff;
      servo_pkg::servo_dir_e    raw;
      diff = $signed({1'b0, pair.pos_side}) - $signed({1'b0, pair.neg_side});
      if (diff > DEADBAND) begin
         raw = servo_pkg::DIR_CW;
      end else if (diff < -DEADBAND) begin
         raw = servo_pkg::DIR_CCW;
      end else begin
         raw = servo_pkg::DIR_STOP;
      end
      // saturated axis just stops
      if (raw == servo_pkg::DIR_CW && status.at_max) begin
         raw = servo_pkg::DIR_STOP;
      end
      if (raw == servo_pkg::DIR_CCW && status.at_min) begin
         raw = servo_pkg::DIR_STOP;
      end
      return raw;
   endfunction

   // live decision from current light and limits
   assign dir_az_d = pick_dir(light.azimuth, status_az);
   assign dir_el_d = pick_dir(light.elevation, status_el);

   // frame_start -> DECIDE -> STEP -> IDLE
   // step comes two cycles after frame_start
   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         dir_az_q <= servo_pkg::DIR_STOP;
         dir_el_q <= servo_pkg::DIR_STOP;
         locked   <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               // en low holds everything
               if (frame_start && en) begin
                  state <= DECIDE;
               end
            end
            DECIDE: begin
               dir_az_q <= dir_az_d;
               dir_el_q <= dir_el_d;
               state    <= STEP;
            end
            STEP: begin
               // both axes idle means panel faces the light
               locked <= (dir_az_q == servo_pkg::DIR_STOP) &&
                         (dir_el_q == servo_pkg::DIR_STOP);
               state  <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // step strobe only in STEP and only for a real move
   always_comb begin
      cmd_az.step = (state == STEP) && (dir_az_q != servo_pkg::DIR_STOP);
      cmd_az.dir  = dir_az_q;
      cmd_el.step = (state == STEP) && (dir_el_q != servo_pkg::DIR_STOP);
      cmd_el.dir  = dir_el_q;
   end

endmodule

// File: design/tick_gen.sv
`timescale 1ns/1ps
`include "tracker_defines.svh"

module tick_gen (
   input  logic clk,
   input  logic rst,
   output logic tick
);

   // divider needs at least one bit
   localparam int CNT_W = (`TRK_TICK_DIV > 1) ? $clog2(`TRK_TICK_DIV) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`TRK_TICK_DIV - 1);

   logic [CNT_W-1:0] cnt;

   // free running divider
   // tick is registered so it lands on the wrap cycle + 1
   always_ff @(posedge clk) begin
      if (rst) begin
         cnt  <= '0;
         tick <= 1'b0;
      end else begin
         if (cnt == CNT_LAST) begin
            cnt  <= '0;
            tick <= 1'b1;
         end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
         end
      end
   end

endmodule

// File: design/servo_pkg.sv
`include "tracker_defines.svh"

package servo_pkg;

   // rotation request per axis
   // stop is the all-zero code
   typedef enum logic [1:0] {
      DIR_STOP = 2'b00,
      DIR_CW   = 2'b01,
      DIR_CCW  = 2'b10
   } servo_dir_e;

   // one-cycle step strobe with its direction
   typedef struct packed {
      logic       step;
      servo_dir_e dir;
   } servo_cmd_t;

   // driver state seen by controller and pwm
   // position is pulse width in microsecond ticks
   typedef struct packed {
      logic                  at_max;
      logic                  at_min;
      logic [`TRK_POS_W-1:0] position;
   } servo_status_t;

endpackage

// File: design/sensor_pkg.sv
`include "tracker_defines.svh"

package sensor_pkg;

   // one opposing sensor pair
   // pos_side brighter means turn clockwise
   typedef struct packed {
      logic [`TRK_LIGHT_W-1:0] pos_side;
      logic [`TRK_LIGHT_W-1:0] neg_side;
   } light_pair_t;

   // full sample from the four sensors
   // azimuth holds east and west
   // elevation holds up and down
   typedef struct packed {
      light_pair_t azimuth;
      light_pair_t elevation;
   } light_sample_t;

endpackage

// File: design/tracker_defines.svh
`ifndef TRACKER_DEFINES_SVH
`define TRACKER_DEFINES_SVH

// clk cycles per microsecond tick
// kept small so a frame simulates quickly
`define TRK_TICK_DIV 4

// ticks per servo frame
`define TRK_FRAME_US 2500

// pulse width limits in ticks
`define TRK_POS_MIN 500
`define TRK_POS_MAX 2000

// neutral pulse width after reset
`define TRK_POS_CENTER 1250

// pulse width change per accepted step
`define TRK_STEP_US 50

// smallest light difference that moves an axis
`define TRK_DEADBAND 64

// position register width
`define TRK_POS_W 12

// width of one light level
`define TRK_LIGHT_W 12

`endif
